// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module imuldiv_tb -f sim.f -o imuldiv_sim \
  && ./obj_dir/imuldiv_sim | tee /dev/stderr | grep -q "^TEST PASS$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
source/imuldiv_pkg.sv
source/imuldiv_ctrl.sv
source/imuldiv_mul_dpath.sv
source/imuldiv_div_dpath.sv
source/imuldiv_sign_unit.sv
source/imuldiv_iterative.sv
verification/imuldiv_tb.sv

// ==== source/imuldiv_ctrl.sv ====
/*
 * Shared control FSM for the multiply/divide unit.
 * Owns both handshakes and sequences load plus 32 step cycles.
 */

`timescale 1ns/1ps

module imuldiv_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  input  imuldiv_pkg::imuldiv_op_e req_op,
  input  logic                     resp_rdy,
  output logic                     req_rdy,
  output logic                     resp_val,
  output logic                     load,
  output logic                     step,
  output imuldiv_pkg::imuldiv_op_e op
);

  import imuldiv_pkg::*;

  // ---------------------------------------------------------------------
  // state and counter
  // ---------------------------------------------------------------------

  imuldiv_state_e state;
  imuldiv_state_e state_next;
  count_t         count;

  // handshake events for this cycle
  logic req_fire;
  logic resp_fire;
  // high on the 32nd CALC cycle
  logic last_step;

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;
  assign last_step = (count == count_t'(31));

  // ---------------------------------------------------------------------
  // outputs, decoded from state only
  // ---------------------------------------------------------------------

  // only accept in IDLE, so a held response blocks new work
  assign req_rdy  = (state == ST_IDLE);
  assign resp_val = (state == ST_DONE);

  // datapaths capture operands in the accepting cycle
  assign load = req_fire;

  // one bit of work per CALC cycle
  assign step = (state == ST_CALC);

  // ---------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req_fire) begin
          state_next = ST_CALC;
        end
      end
      ST_CALC: begin
        // 32 steps done, result is final on this edge
        if (last_step) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        // wait here as long as the consumer stalls
        if (resp_fire) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
      op    <= OP_MUL;
    end else begin
      state <= state_next;
      // counter restarts at acceptance, counts up through CALC
      if (req_fire) begin
        count <= '0;
        op    <= req_op;
      end else if (step) begin
        count <= count + count_t'(1);
      end
    end
  end

endmodule

// ==== source/imuldiv_div_dpath.sv ====
/*
 * Restoring shift-subtract divider on unsigned 32-bit magnitudes.
 * Loads on load and produces one quotient bit per step.
 */

`timescale 1ns/1ps

module imuldiv_div_dpath (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  logic               step,
  input  imuldiv_pkg::word_t a_mag,
  input  imuldiv_pkg::word_t b_mag,
  output imuldiv_pkg::word_t quot_mag,
  output imuldiv_pkg::word_t rem_mag
);

  import imuldiv_pkg::*;

  // ---------------------------------------------------------------------
  // registers
  // ---------------------------------------------------------------------

  // partial remainder
  word_t rem;
  // holds the dividend at load, quotient bits shift in from the right
  word_t quot;
  // divisor, constant for the whole operation
  word_t divisor;

  // ---------------------------------------------------------------------
  // trial subtraction
  // ---------------------------------------------------------------------

  // remainder with the next dividend bit shifted in, one extra bit
  logic [32:0] rem_shift;
  // bit 32 set means the subtraction went negative
  logic [32:0] rem_diff;
  logic        q_bit;

  assign rem_shift = {rem, quot[31]};
  assign rem_diff  = rem_shift - {1'b0, divisor};
  assign q_bit     = ~rem_diff[32];

  always_ff @(posedge clk) begin
    if (reset) begin
      rem <= '0;
    end else if (load) begin
      rem <= '0;
    end else if (step) begin
      // keep the difference only when it fits, else restore
      if (q_bit) begin
        rem <= rem_diff[31:0];
      end else begin
        rem <= rem_shift[31:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      quot    <= a_mag;
      divisor <= b_mag;
    end else if (step) begin
      // a zero divisor never goes negative, giving all ones here
      quot <= {quot[30:0], q_bit};
    end
  end

  // ---------------------------------------------------------------------
  // outputs
  // ---------------------------------------------------------------------

  // both final after the 32nd step
  assign quot_mag = quot;
  assign rem_mag  = rem;

endmodule

// ==== source/imuldiv_iterative.sv ====
/*
 * Iterative multiply/divide unit, one operation in flight.
 * Valid/ready request in, 64-bit response out after 32 cycles.
 */

`timescale 1ns/1ps

module imuldiv_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req_msg,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp_msg,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  import imuldiv_pkg::*;

  // ---------------------------------------------------------------------
  // internal nets
  // ---------------------------------------------------------------------

  // sequencing from the FSM
  logic        load;
  logic        step;
  imuldiv_op_e op;

  // magnitudes into the datapaths
  word_t  a_mag;
  word_t  b_mag;

  // raw results out of the datapaths
  dword_t product_mag;
  word_t  quot_mag;
  word_t  rem_mag;

  // signed result back from the sign unit
  dword_t result;

  assign resp_msg.result = result;

  // ---------------------------------------------------------------------
  // control and datapaths
  // ---------------------------------------------------------------------

  imuldiv_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_op   (req_msg.op),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .load     (load),
    .step     (step),
    .op       (op)
  );

  imuldiv_sign_unit u_sign_unit (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .req_op      (req_msg.op),
    .op          (op),
    .a           (req_msg.a),
    .b           (req_msg.b),
    .product_mag (product_mag),
    .quot_mag    (quot_mag),
    .rem_mag     (rem_mag),
    .a_mag       (a_mag),
    .b_mag       (b_mag),
    .result      (result)
  );

  // both datapaths run every operation, the sign unit picks one
  imuldiv_mul_dpath u_mul_dpath (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .step        (step),
    .a_mag       (a_mag),
    .b_mag       (b_mag),
    .product_mag (product_mag)
  );

  imuldiv_div_dpath u_div_dpath (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .a_mag    (a_mag),
    .b_mag    (b_mag),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag)
  );

endmodule

// ==== source/imuldiv_mul_dpath.sv ====
/*
 * Shift-add multiplier on unsigned 32-bit magnitudes.
 * Loads on load and retires one multiplier bit per step.
 */

`timescale 1ns/1ps

module imuldiv_mul_dpath (
  input  logic                clk,
  input  logic                reset,
  input  logic                load,
  input  logic                step,
  input  imuldiv_pkg::word_t  a_mag,
  input  imuldiv_pkg::word_t  b_mag,
  output imuldiv_pkg::dword_t product_mag
);

  import imuldiv_pkg::*;

  // ---------------------------------------------------------------------
  // registers
  // ---------------------------------------------------------------------

  // multiplicand moves left one place per step
  dword_t mcand;
  // multiplier moves right, bit 0 decides the add
  word_t  mplier;
  // running sum of partial products
  dword_t acc;

  // partial sum for the current step
  dword_t acc_sum;

  assign acc_sum = acc + mcand;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc    <= '0;
      mplier <= '0;
    end else if (load) begin
      acc    <= '0;
      mplier <= b_mag;
    end else if (step) begin
      // add only when this multiplier bit is set
      if (mplier[0]) begin
        acc <= acc_sum;
      end
      mplier <= mplier >> 1;
    end
  end

  // multiplicand is pure payload
  always_ff @(posedge clk) begin
    if (load) begin
      // zero extend so the high half can absorb the shifts
      mcand <= {32'b0, a_mag};
    end else if (step) begin
      mcand <= mcand << 1;
    end
  end

  // ---------------------------------------------------------------------
  // output
  // ---------------------------------------------------------------------

  // final after the 32nd step, held until the next load
  assign product_mag = acc;

endmodule

// ==== source/imuldiv_pkg.sv ====
/*
 * Shared types for the iterative multiply/divide unit.
 * Imported by every RTL module and by the testbench.
 */

package imuldiv_pkg;

  // ---------------------------------------------------------------------
  // data widths
  // ---------------------------------------------------------------------

  // operand, quotient or remainder
  typedef logic [31:0] word_t;

  // full product or packed {remainder, quotient} result
  typedef logic [63:0] dword_t;

  // iteration counter, one value per CALC step
  typedef logic [4:0] count_t;

  // ---------------------------------------------------------------------
  // operations and messages
  // ---------------------------------------------------------------------

  // all division ops return {rem, quot}, the op only picks signedness
  typedef enum logic [2:0] {
    OP_MUL  = 3'd0,
    OP_DIV  = 3'd1,
    OP_DIVU = 3'd2,
    OP_REM  = 3'd3,
    OP_REMU = 3'd4
  } imuldiv_op_e;

  // request message, a is multiplicand or dividend
  typedef struct packed {
    imuldiv_op_e op;
    word_t       a;
    word_t       b;
  } imuldiv_req_t;

  // response message
  typedef struct packed {
    dword_t result;
  } imuldiv_resp_t;

  // control FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } imuldiv_state_e;

endpackage

// ==== source/imuldiv_sign_unit.sv ====
/*
 * Sign handling around the magnitude datapaths.
 * Makes operand magnitudes and applies signs to the final result.
 */

`timescale 1ns/1ps

module imuldiv_sign_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  imuldiv_pkg::imuldiv_op_e req_op,
  input  imuldiv_pkg::imuldiv_op_e op,
  input  imuldiv_pkg::word_t       a,
  input  imuldiv_pkg::word_t       b,
  input  imuldiv_pkg::dword_t      product_mag,
  input  imuldiv_pkg::word_t       quot_mag,
  input  imuldiv_pkg::word_t       rem_mag,
  output imuldiv_pkg::word_t       a_mag,
  output imuldiv_pkg::word_t       b_mag,
  output imuldiv_pkg::dword_t      result
);

  import imuldiv_pkg::*;

  // ---------------------------------------------------------------------
  // operand magnitudes, from the raw request
  // ---------------------------------------------------------------------

  logic req_signed;
  logic a_neg;
  logic b_neg;

  // unsigned ops pass operands straight through
  assign req_signed = (req_op != OP_DIVU) && (req_op != OP_REMU);
  assign a_neg      = req_signed && a[31];
  assign b_neg      = req_signed && b[31];

  // most negative value maps onto itself, which is right as unsigned
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  // signs of the operation in flight
  logic sign_a;
  logic sign_b;
  logic b_zero;

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
      b_zero <= 1'b0;
    end else if (load) begin
      sign_a <= a_neg;
      sign_b <= b_neg;
      b_zero <= (b == '0);
    end
  end

  // ---------------------------------------------------------------------
  // result sign fix
  // ---------------------------------------------------------------------

  logic  signs_differ;
  word_t quot;
  word_t rem;

  assign signs_differ = sign_a ^ sign_b;

  // divide by zero keeps the all ones quotient
  assign quot = (signs_differ && !b_zero) ? -quot_mag : quot_mag;
  // remainder follows the dividend
  assign rem  = sign_a ? -rem_mag : rem_mag;

  assign result = (op == OP_MUL) ? (signs_differ ? -product_mag : product_mag)
                                 : {rem, quot};

endmodule

// ==== verification/imuldiv_tb.sv ====
/*
 * Directed testbench for the iterative multiply/divide unit.
 * Runs every op against a wide-arithmetic model and checks latency and back-pressure.
 */

`timescale 1ns/1ps

module imuldiv_tb;

  import imuldiv_pkg::*;

  // watchdog limit scales with the ops issued over the whole run
  localparam int num_ops         = 199;
  localparam int watchdog_cycles = num_ops * 40 + 8 + 200;

  logic          clk;
  logic          reset;
  imuldiv_req_t  req_msg;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp_msg;
  logic          resp_val;
  logic          resp_rdy;
  integer        seed;

  imuldiv_iterative u_imuldiv_iterative (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ends a run that stops making progress
  initial begin
    #(watchdog_cycles * 10);
    $display("watchdog expired, the DUT stopped responding");
    $display("TEST FAIL");
    $fatal(1, "simulation timed out");
  end

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------

  task automatic check_resp(input string name, input imuldiv_resp_t exp,
                            input imuldiv_resp_t act);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp.result, act.result);
      $display("TEST FAIL");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_ctrl(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "handshake mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // reference model in 64-bit signed arithmetic
  // ----------------------------------------------------------------------

  task automatic model_resp(input imuldiv_req_t req, output imuldiv_resp_t exp);
    longint sa;
    longint sb;
    longint q;
    longint r;
    logic   signed_op;
    signed_op = (req.op == OP_MUL) || (req.op == OP_DIV) || (req.op == OP_REM);
    if (signed_op) begin
      sa = longint'($signed(req.a));
      sb = longint'($signed(req.b));
    end else begin
      sa = {32'b0, req.a};
      sb = {32'b0, req.b};
    end
    if (req.op == OP_MUL) begin
      exp.result = sa * sb;
    end else if (req.b == '0) begin
      // divide by zero returns all ones and the dividend
      exp.result = {req.a, 32'hffff_ffff};
    end else begin
      // truncating division keeps the dividend sign on the remainder
      // min / -1 gives +2^31 whose low word wraps back to min
      q = sa / sb;
      r = sa % sb;
      exp.result = {r[31:0], q[31:0]};
    end
  endtask

  // ----------------------------------------------------------------------
  // one operation with latency checks and an optional stall
  // ----------------------------------------------------------------------

  // starts and ends 1 ns after a rising edge with the unit idle
  task automatic run_op(input imuldiv_op_e op, input word_t a, input word_t b,
                        input int stall);
    imuldiv_req_t  req;
    imuldiv_resp_t exp;
    int            cyc;
    req.op = op;
    req.a  = a;
    req.b  = b;
    model_resp(req, exp);
    check_ctrl("req_rdy", 1'b1, req_rdy);
    req_msg = req;
    req_val = 1'b1;
    // accepting edge
    @(posedge clk);
    #1;
    req_val = 1'b0;
    req_msg = '0;
    // busy through CALC with the response on the 32nd edge
    for (cyc = 1; cyc <= 32; cyc++) begin
      @(posedge clk);
      #1;
      check_ctrl("req_rdy", 1'b0, req_rdy);
      check_ctrl("resp_val", cyc == 32, resp_val);
    end
    check_resp("resp_msg", exp, resp_msg);
    // result must hold while the consumer stalls
    for (cyc = 0; cyc < stall; cyc++) begin
      @(posedge clk);
      #1;
      check_ctrl("resp_val", 1'b1, resp_val);
      check_ctrl("req_rdy", 1'b0, req_rdy);
      check_resp("resp_msg", exp, resp_msg);
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
    // back in idle one cycle after the take
    check_ctrl("req_rdy", 1'b1, req_rdy);
    check_ctrl("resp_val", 1'b0, resp_val);
  endtask

  task automatic run_div_ops(input word_t a, input word_t b);
    run_op(OP_DIV, a, b, 0);
    run_op(OP_DIVU, a, b, 0);
    run_op(OP_REM, a, b, 0);
    run_op(OP_REMU, a, b, 0);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------

  task automatic test_reset_state();
    check_ctrl("req_rdy", 1'b1, req_rdy);
    check_ctrl("resp_val", 1'b0, resp_val);
  endtask

  task automatic test_mul();
    word_t a;
    word_t b;
    int    i;
    run_op(OP_MUL, 32'd12345, 32'd6789, 0);
    run_op(OP_MUL, -32'sd77, 32'd1000, 0);
    run_op(OP_MUL, 32'd3, -32'sd9, 0);
    run_op(OP_MUL, -32'sd40000, -32'sd50000, 0);
    run_op(OP_MUL, 32'd0, -32'sd5, 0);
    run_op(OP_MUL, 32'h7fff_ffff, 32'd0, 0);
    run_op(OP_MUL, 32'h8000_0000, 32'h8000_0000, 0);
    run_op(OP_MUL, 32'h8000_0000, 32'd1, 0);
    run_op(OP_MUL, 32'h7fff_ffff, 32'h8000_0000, 0);
    for (i = 0; i < 50; i++) begin
      a = $random(seed);
      b = $random(seed);
      run_op(OP_MUL, a, b, 0);
    end
  endtask

  task automatic test_div();
    word_t a;
    word_t b;
    int    i;
    run_div_ops(32'd7, 32'd2);
    run_div_ops(-32'sd7, 32'd2);
    run_div_ops(32'd7, -32'sd2);
    run_div_ops(-32'sd7, -32'sd2);
    run_div_ops(32'd100, 32'd7);
    run_div_ops(-32'sd100, -32'sd7);
    run_div_ops(32'd0, 32'd5);
    run_div_ops(32'd5, 32'd7);
    run_div_ops(32'h8000_0000, 32'd3);
    run_div_ops(32'hffff_ffff, 32'd16);
    // spread divisor sizes by a random right shift
    for (i = 0; i < 20; i++) begin
      a = $random(seed);
      b = word_t'($random(seed)) >> ($unsigned($random(seed)) % 32);
      run_div_ops(a, b);
    end
  endtask

  task automatic test_div_corners();
    run_div_ops(32'd1234, 32'd0);
    run_div_ops(-32'sd1234, 32'd0);
    run_div_ops(32'h8000_0000, 32'd0);
    // on overflow the quotient wraps to the dividend
    run_div_ops(32'h8000_0000, 32'hffff_ffff);
  endtask

  task automatic test_back_pressure();
    int    stall;
    word_t a;
    word_t b;
    stall = 1 + ($unsigned($random(seed)) % 20);
    a = $random(seed);
    b = $random(seed);
    run_op(OP_MUL, a, b, stall);
    stall = 1 + ($unsigned($random(seed)) % 20);
    run_op(OP_DIV, b, 32'd13, stall);
    stall = 1 + ($unsigned($random(seed)) % 20);
    run_op(OP_REMU, a, 32'd0, stall);
    // follow-up without stall
    run_op(OP_REM, -32'sd99, 32'd10, 0);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    seed     = 32'ha8ba;
    reset    = 1'b1;
    req_msg  = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_mul();
    test_div();
    test_div_corners();
    test_back_pressure();
    $display("TEST PASS");
    $finish;
  end

endmodule
